// ==== barrelCore.f ====
design/rvIsaPkg.sv
design/barrelPkg.sv
design/threadSequencer.sv
design/pcCounter.sv
design/instDecoder.sv
design/regBank.sv
design/aluExec.sv
design/barrelCore.sv
testbench/barrelCoreTb.sv

// ==== design/aluExec.sv ====
/*
 * Q101H execute.
 * Selects the ALU operands, runs the decoded operation, compares rs1
 * with rs2 for branches and resolves the thread's next PC. Jumps
 * return the link address as their result.
 */
`timescale 1ns/1ns

module aluExec (
    input  barrelPkg::decodeT dec,
    input  rvIsaPkg::xlenT    pc,
    input  rvIsaPkg::xlenT    rs1Data,
    input  rvIsaPkg::xlenT    rs2Data,
    output rvIsaPkg::xlenT    result,
    output rvIsaPkg::xlenT    nextPc
);
    import rvIsaPkg::*;

    xlenT               in1;
    xlenT               in2;
    xlenT               aluOut;
    xlenT               pcPlusStep;
    xlenT               pcTarget;
    logic [SHAMT_W-1:0] shamt;
    logic               taken;

    //////////////////////////////////////////////////
    // Operands and ALU
    //////////////////////////////////////////////////
    assign in1   = dec.zeroIn1 ? '0 : (dec.usePc ? pc : rs1Data);
    assign in2   = dec.useImm ? dec.imm : rs2Data;
    assign shamt = in2[SHAMT_W-1:0];

    always_comb begin
        case (dec.aluOp)
            ALU_ADD:  aluOut = in1 + in2;
            ALU_SUB:  aluOut = in1 - in2;
            ALU_SLT:  aluOut = {{(XLEN-1){1'b0}}, $signed(in1) < $signed(in2)};
            ALU_SLTU: aluOut = {{(XLEN-1){1'b0}}, in1 < in2};
            ALU_SLL:  aluOut = in1 << shamt;
            ALU_SRL:  aluOut = in1 >> shamt;
            ALU_SRA:  aluOut = $signed(in1) >>> shamt;     // Sign fill
            ALU_XOR:  aluOut = in1 ^ in2;
            ALU_OR:   aluOut = in1 | in2;
            ALU_AND:  aluOut = in1 & in2;
            default:  aluOut = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // Branch compare, rs1 against rs2
    //////////////////////////////////////////////////
    always_comb begin
        case (dec.funct3)
            F3_BEQ:  taken = (rs1Data == rs2Data);
            F3_BNE:  taken = (rs1Data != rs2Data);
            F3_BLT:  taken = ($signed(rs1Data) < $signed(rs2Data));
            F3_BGE:  taken = ($signed(rs1Data) >= $signed(rs2Data));
            F3_BLTU: taken = (rs1Data < rs2Data);
            F3_BGEU: taken = (rs1Data >= rs2Data);
            default: taken = 1'b0;
        endcase
        taken = taken & dec.isBranch;
    end

    //////////////////////////////////////////////////
    // Result and next PC
    //////////////////////////////////////////////////
    assign pcPlusStep = pc + PC_STEP;
    assign pcTarget   = pc + dec.imm;                 // JAL and branch target

    assign result = (dec.isJal || dec.isJalr) ? pcPlusStep : aluOut;

    always_comb begin
        if (dec.isJalr) begin
            nextPc = {aluOut[XLEN-1:1], 1'b0};        // rs1 + imm, bit 0 cleared
        end else if (dec.isJal || taken) begin
            nextPc = pcTarget;
        end else begin
            nextPc = pcPlusStep;
        end
    end

endmodule

// ==== design/barrelCore.sv ====
/*
 * Four-thread barrel RV32I core.
 * One thread per clock enters Q100H fetch. Q101H decodes, reads the
 * registers, executes and resolves the next PC, Q102H stages the
 * result and Q103H writes it back. Instruction memory answers in one cycle.
 */
`timescale 1ns/1ns

module barrelCore (
    input  logic                QClk,
    input  logic                rstN,
    output barrelPkg::fetchReqT fetchReq,
    input  rvIsaPkg::xlenT      instFetch,
    output barrelPkg::retireT   retire
);
    import rvIsaPkg::*;
    import barrelPkg::*;

    threadT   threadQ100H;
    xlenT     pcQ100H;
    fetchReqT fetchQ101H;       // Thread and PC of the word in instFetch
    logic     validQ101H;
    decodeT   dec;
    xlenT     rs1Data;
    xlenT     rs2Data;
    xlenT     resultQ101H;
    xlenT     nextPcQ101H;
    retireT   retireQ101H;
    retireT   retireQ102H;

    //////////////////////////////////////////////////
    // Q100H fetch
    //////////////////////////////////////////////////
    threadSequencer u_threadSequencer (
        .QClk        (QClk),
        .rstN        (rstN),
        .threadQ100H (threadQ100H)
    );

    pcCounter u_pcCounter (
        .QClk        (QClk),
        .rstN        (rstN),
        .threadQ100H (threadQ100H),
        .pcQ100H     (pcQ100H),
        .loadEn      (validQ101H),          // Only real instructions move a PC
        .loadThread  (fetchQ101H.thread),
        .nextPc      (nextPcQ101H)
    );

    assign fetchReq.thread = threadQ100H;
    assign fetchReq.pc     = pcQ100H;

    always_ff @(posedge QClk) begin
        fetchQ101H <= fetchReq;
        if (!rstN) begin
            validQ101H <= 1'b0;             // Drops the word fetched in reset
        end else begin
            validQ101H <= 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Q101H decode, read, execute
    //////////////////////////////////////////////////
    instDecoder u_instDecoder (
        .inst (instFetch),
        .dec  (dec)
    );

    regBank u_regBank (
        .QClk     (QClk),
        .rstN     (rstN),
        .rdThread (fetchQ101H.thread),
        .rs1      (dec.rs1),
        .rs2      (dec.rs2),
        .rs1Data  (rs1Data),
        .rs2Data  (rs2Data),
        .wr       (retire)                  // Q103H write back
    );

    aluExec u_aluExec (
        .dec     (dec),
        .pc      (fetchQ101H.pc),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .result  (resultQ101H),
        .nextPc  (nextPcQ101H)
    );

    always_comb begin
        retireQ101H.valid  = validQ101H && dec.regWr && (dec.rd != '0);
        retireQ101H.thread = fetchQ101H.thread;
        retireQ101H.rd     = dec.rd;
        retireQ101H.data   = resultQ101H;
    end

    //////////////////////////////////////////////////
    // Q102H staging and Q103H write back
    //////////////////////////////////////////////////
    always_ff @(posedge QClk) begin
        retireQ102H <= retireQ101H;
        retire      <= retireQ102H;
        if (!rstN) begin
            retireQ102H.valid <= 1'b0;      // Payload keeps flowing
            retire.valid      <= 1'b0;
        end
    end

endmodule

// ==== design/barrelPkg.sv ====
/*
 * Organisation of the four-thread barrel core.
 * Thread slots, per-thread reset addresses and the structs that carry
 * the fetch request, the decoded instruction and the retired write.
 */
package barrelPkg;
    import rvIsaPkg::*;

    //////////////////////////////////////////////////
    // Threads
    //////////////////////////////////////////////////
    localparam int NUM_THREADS = 4;

    typedef enum logic [1:0] {
        T0,
        T1,
        T2,
        T3
    } threadT;

    // Reset PC of each thread, one code window each
    localparam xlenT THREAD_BASE [NUM_THREADS] = '{
        32'h0000_0000,
        32'h0000_0100,
        32'h0000_0200,
        32'h0000_0300
    };

    //////////////////////////////////////////////////
    // Pipe structs
    //////////////////////////////////////////////////
    typedef struct packed {
        threadT thread;     // Slot issuing this fetch
        xlenT   pc;
    } fetchReqT;

    typedef struct packed {
        regIdxT rs1;
        regIdxT rs2;
        regIdxT rd;         // x0 when nothing is written
        aluOpT  aluOp;
        logic   usePc;      // Operand 1 is the PC
        logic   useImm;     // Operand 2 is the immediate
        logic   zeroIn1;    // Operand 1 is zero
        xlenT   imm;
        logic   regWr;
        logic   isBranch;
        logic   isJal;
        logic   isJalr;
        funct3T funct3;     // Branch compare type
    } decodeT;

    typedef struct packed {
        logic   valid;
        threadT thread;
        regIdxT rd;
        xlenT   data;
    } retireT;

endpackage

// ==== design/instDecoder.sv ====
/*
 * Q101H instruction decode.
 * Splits the fetched word into register fields, builds the immediate
 * its opcode needs and sets the operand sources, control flags and
 * ALU operation. Unknown opcodes decode to a no-write instruction.
 */
`timescale 1ns/1ns

module instDecoder (
    input  rvIsaPkg::xlenT    inst,
    output barrelPkg::decodeT dec
);
    import rvIsaPkg::*;

    opcodeT opcode;
    funct3T funct3;
    logic   funct7b5;
    logic   isShiftImm;
    xlenT   iImm;
    xlenT   bImm;
    xlenT   uImm;
    xlenT   jImm;

    //////////////////////////////////////////////////
    // Fields and immediates
    //////////////////////////////////////////////////
    assign opcode   = inst[6:0];
    assign funct3   = inst[14:12];
    assign funct7b5 = inst[30];     // SUB and SRA select

    assign iImm = {{20{inst[31]}}, inst[31:20]};
    assign bImm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign uImm = {inst[31:12], 12'b0};
    assign jImm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    assign isShiftImm = (funct3 == F3_SLL) || (funct3 == F3_SR);

    //////////////////////////////////////////////////
    // Control
    //////////////////////////////////////////////////
    always_comb begin
        dec.rs1      = inst[19:15];
        dec.rs2      = inst[24:20];
        dec.rd       = inst[11:7];
        dec.funct3   = funct3;
        dec.aluOp    = ALU_ADD;     // Address and upper-immediate adds
        dec.usePc    = 1'b0;
        dec.useImm   = 1'b0;
        dec.zeroIn1  = 1'b0;
        dec.imm      = iImm;
        dec.regWr    = 1'b0;
        dec.isBranch = 1'b0;
        dec.isJal    = 1'b0;
        dec.isJalr   = 1'b0;

        case (opcode)
            OP_LUI: begin
                dec.zeroIn1 = 1'b1;     // 0 + U immediate
                dec.useImm  = 1'b1;
                dec.imm     = uImm;
                dec.regWr   = 1'b1;
            end
            OP_AUIPC: begin
                dec.usePc  = 1'b1;      // PC + U immediate
                dec.useImm = 1'b1;
                dec.imm    = uImm;
                dec.regWr  = 1'b1;
            end
            OP_JAL: begin
                dec.isJal = 1'b1;
                dec.imm   = jImm;
                dec.regWr = 1'b1;       // Link
            end
            OP_JALR: begin
                dec.isJalr = 1'b1;
                dec.useImm = 1'b1;      // ALU forms rs1 + imm
                dec.regWr  = 1'b1;
            end
            OP_BRANCH: begin
                dec.isBranch = 1'b1;
                dec.imm      = bImm;
            end
            OP_OPIMM: begin
                dec.useImm = 1'b1;
                dec.regWr  = 1'b1;
                dec.aluOp  = aluOpT'({isShiftImm & funct7b5, funct3});
            end
            OP_OP: begin
                dec.regWr = 1'b1;
                dec.aluOp = aluOpT'({funct7b5, funct3});
            end
            default: ;                  // No write, falls through to PC+4
        endcase

        if (!dec.regWr) begin
            dec.rd = '0;                // Branches and unknown opcodes
        end
    end

endmodule

// ==== design/pcCounter.sv ====
/*
 * Per-thread program counters.
 * One counter per slot, reset to the thread's base address. The
 * counter of the slot in Q100H goes out as the fetch PC, and the
 * Q101H thread loads its resolved next PC on the following clock.
 */
`timescale 1ns/1ns

module pcCounter (
    input  logic              QClk,
    input  logic              rstN,
    input  barrelPkg::threadT threadQ100H,
    output rvIsaPkg::xlenT    pcQ100H,
    input  logic              loadEn,
    input  barrelPkg::threadT loadThread,
    input  rvIsaPkg::xlenT    nextPc
);
    import rvIsaPkg::*;
    import barrelPkg::*;

    xlenT pcs [NUM_THREADS];    // One PC per thread

    always_ff @(posedge QClk) begin
        if (!rstN) begin
            for (int t = 0; t < NUM_THREADS; t++) begin
                pcs[t] <= THREAD_BASE[t];
            end
        end else if (loadEn) begin
            pcs[loadThread] <= nextPc;  // Never the slot being fetched
        end
    end

    // Current slot picks its counter
    assign pcQ100H = pcs[threadQ100H];

endmodule

// ==== design/regBank.sv ====
/*
 * Register file of the barrel core.
 * Four banks of 32 words, one per thread. Two combinational read ports
 * serve the Q101H thread and the Q103H retire writes on the next clock.
 */
`timescale 1ns/1ns

module regBank (
    input  logic              QClk,
    input  logic              rstN,
    input  barrelPkg::threadT rdThread,
    input  rvIsaPkg::regIdxT  rs1,
    input  rvIsaPkg::regIdxT  rs2,
    output rvIsaPkg::xlenT    rs1Data,
    output rvIsaPkg::xlenT    rs2Data,
    input  barrelPkg::retireT wr
);
    import rvIsaPkg::*;
    import barrelPkg::*;

    xlenT regs [NUM_THREADS][REG_COUNT];

    //////////////////////////////////////////////////
    // Write port
    //////////////////////////////////////////////////
    always_ff @(posedge QClk) begin
        if (!rstN) begin
            for (int t = 0; t < NUM_THREADS; t++) begin
                for (int r = 0; r < REG_COUNT; r++) begin
                    regs[t][r] <= '0;
                end
            end
        end else if (wr.valid && (wr.rd != '0)) begin
            regs[wr.thread][wr.rd] <= wr.data;
        end
    end

    //////////////////////////////////////////////////
    // Read ports
    //////////////////////////////////////////////////
    assign rs1Data = (rs1 == '0) ? '0 : regs[rdThread][rs1];   // x0 reads zero
    assign rs2Data = (rs2 == '0) ? '0 : regs[rdThread][rs2];

endmodule

// ==== design/rvIsaPkg.sv ====
/*
 * RV32I instruction-set definitions for the barrel core.
 * Word and field types, the opcodes the core executes, the funct3
 * codes for branches and shifts, and the ALU operation set.
 * Modules take it with a wildcard import in their body.
 */
package rvIsaPkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////
    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;
    localparam int REG_COUNT = 32;   // Architectural registers per thread
    localparam int OPCODE_W  = 7;
    localparam int FUNCT3_W  = 3;
    localparam int SHAMT_W   = 5;    // Low bits of operand 2 used by shifts

    typedef logic [XLEN-1:0]      xlenT;
    typedef logic [REG_IDX_W-1:0] regIdxT;
    typedef logic [OPCODE_W-1:0]  opcodeT;
    typedef logic [FUNCT3_W-1:0]  funct3T;

    //////////////////////////////////////////////////
    // Opcodes
    //////////////////////////////////////////////////
    localparam opcodeT OP_LUI    = 7'b0110111;
    localparam opcodeT OP_AUIPC  = 7'b0010111;
    localparam opcodeT OP_JAL    = 7'b1101111;
    localparam opcodeT OP_JALR   = 7'b1100111;
    localparam opcodeT OP_BRANCH = 7'b1100011;
    localparam opcodeT OP_OPIMM  = 7'b0010011;
    localparam opcodeT OP_OP     = 7'b0110011;

    // Branch compare codes
    localparam funct3T F3_BEQ  = 3'b000;
    localparam funct3T F3_BNE  = 3'b001;
    localparam funct3T F3_BLT  = 3'b100;
    localparam funct3T F3_BGE  = 3'b101;
    localparam funct3T F3_BLTU = 3'b110;
    localparam funct3T F3_BGEU = 3'b111;

    // Shift codes, funct7 bit 5 picks SRL or SRA
    localparam funct3T F3_SLL = 3'b001;
    localparam funct3T F3_SR  = 3'b101;

    //////////////////////////////////////////////////
    // ALU operations, encoded {funct7[5], funct3}
    //////////////////////////////////////////////////
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111,
        ALU_SUB  = 4'b1000,
        ALU_SRA  = 4'b1101
    } aluOpT;

    localparam xlenT PC_STEP = 32'd4;   // One 32-bit instruction

endpackage

// ==== design/threadSequencer.sv ====
/*
 * Thread slot rotation for the barrel core.
 * Steps T0, T1, T2, T3 one slot per clock and restarts at T0 on reset.
 * Every later stage carries the slot along in its pipe registers.
 */
`timescale 1ns/1ns

module threadSequencer (
    input  logic              QClk,
    input  logic              rstN,
    output barrelPkg::threadT threadQ100H
);
    import barrelPkg::*;

    threadT nextThread;

    // Fixed rotation
    always_comb begin
        case (threadQ100H)
            T0:      nextThread = T1;
            T1:      nextThread = T2;
            T2:      nextThread = T3;
            T3:      nextThread = T0;
            default: nextThread = T0;
        endcase
    end

    always_ff @(posedge QClk) begin
        if (!rstN) begin
            threadQ100H <= T0;          // First slot after reset
        end else begin
            threadQ100H <= nextThread;
        end
    end

endmodule

// ==== runSim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f barrelCore.f --top-module barrelCoreTb -o simv

out=$(./obj_dir/simv 2>&1 || true)
echo "$out"

if grep -q "Everything OK" <<< "$out"; then
    exit 0
else
    exit 1
fi

// ==== testbench/barrelCoreTb.sv ====
/*
 * Testbench for the barrel core.
 * Loads per-thread programs and expected writebacks from the test data
 * file, models a one-cycle instruction memory and checks every retire
 * against its thread's expected sequence. Also checks thread rotation,
 * reset PCs, jump targets on the fetch PC and that fetches stay inside
 * each thread's code window.
 */
`timescale 1ns/1ns

module barrelCoreTb;
    import rvIsaPkg::*;
    import barrelPkg::*;

    localparam int MEM_WORDS = 64;      // Words per thread window
    localparam int MAX_EXP   = 32;
    localparam int TIMEOUT   = 400;

    logic     QClk = 1'b0;              // Low from the start, no edge at time 0
    logic     rstN;
    fetchReqT fetchReq;
    xlenT     instFetch;
    retireT   retire;

    xlenT     imem [NUM_THREADS][MEM_WORDS];
    regIdxT   expRd [NUM_THREADS][MAX_EXP];
    xlenT     expData [NUM_THREADS][MAX_EXP];
    int       expCount [NUM_THREADS];
    int       gotCount [NUM_THREADS];
    logic     firstSeen [NUM_THREADS];
    xlenT     shadowRegs [NUM_THREADS][REG_COUNT];  // Retired values, already checked
    xlenT     expNextPc [NUM_THREADS];
    logic     jumpPending [NUM_THREADS];            // Next fetch must hit expNextPc
    fetchReqT lastReq;
    threadT   prevThread;
    int       cyc;

    barrelCore u_barrelCore (
        .QClk      (QClk),
        .rstN      (rstN),
        .fetchReq  (fetchReq),
        .instFetch (instFetch),
        .retire    (retire)
    );

    always #20 QClk = ~QClk;            // 40 ns period

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "Run aborted");
    endtask

    task automatic checkValue(input string testName, input xlenT expected, input xlenT actual);
        if (expected !== actual) begin
            $display("[ERROR] %s expected %h actual %h", testName, expected, actual);
            $display("Something failed");
            $fatal(1, "Value mismatch");
        end
    endtask

    // Slot that follows s in the fixed rotation
    function automatic threadT nextSlot(input threadT s);
        return threadT'((int'(s) + 1) % NUM_THREADS);
    endfunction

    // Where a served JAL or JALR must send its thread, from the ISA encoding
    task automatic noteJump(input fetchReqT req, input xlenT word);
        xlenT jOff;
        xlenT iOff;
        jOff = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
        iOff = {{20{word[31]}}, word[31:20]};
        if (word[6:0] == OP_JAL) begin
            expNextPc[req.thread]   = req.pc + jOff;
            jumpPending[req.thread] = 1'b1;
        end else if (word[6:0] == OP_JALR) begin
            expNextPc[req.thread]   = (shadowRegs[req.thread][word[19:15]] + iOff) & ~32'd1;
            jumpPending[req.thread] = 1'b1;
        end
    endtask

    task automatic loadTestdata();
        int        fd;
        int        n;
        int        t;
        int        idx;
        xlenT      word;
        logic [7:0] tag;
        logic [8*200-1:0] lineBuf;
        fd = $fopen("testbench/barrelTestdata.txt", "r");
        if (fd == 0) abortRun("Cannot open the test data file");
        while ($fscanf(fd, " %s", tag) == 1) begin
            if (tag == "#") begin
                n = $fgets(lineBuf, fd);       // Rest of comment line
            end else begin
                n = $fscanf(fd, "%d %d %h", t, idx, word);
                if (n != 3) abortRun("Malformed line in the test data file");
                if (tag == "I") begin
                    imem[t][idx] = word;
                end else begin
                    expRd[t][expCount[t]]   = regIdxT'(idx);
                    expData[t][expCount[t]] = word;
                    expCount[t]++;
                end
            end
        end
        $fclose(fd);
    endtask

    //////////////////////////////////////////////////
    // Memory model, fetch and retire monitor
    //////////////////////////////////////////////////
    always @(negedge QClk) begin
        xlenT off;
        xlenT word;
        off = lastReq.pc - THREAD_BASE[lastReq.thread];
        if (off[31:8] != '0) abortRun("Fetch PC left the thread's code window");
        word      = imem[lastReq.thread][off[7:2]];
        instFetch <= word;              // Word for last cycle's fetch
        if (rstN) begin
            noteJump(lastReq, word);    // Fetches made in reset are dropped
        end
        lastReq = fetchReq;

        if (!firstSeen[fetchReq.thread]) begin
            checkValue("first pc", THREAD_BASE[fetchReq.thread], fetchReq.pc);
            firstSeen[fetchReq.thread] = 1'b1;
        end
        if (jumpPending[fetchReq.thread]) begin
            checkValue($sformatf("T%0d jump target", fetchReq.thread),
                expNextPc[fetchReq.thread], fetchReq.pc);
            jumpPending[fetchReq.thread] = 1'b0;
        end
        if (rstN) begin
            cyc++;
            checkValue("rotation", xlenT'(nextSlot(prevThread)), xlenT'(fetchReq.thread));
            if (retire.valid) begin
                if (cyc < 3) abortRun("Retire valid before the first instruction reached Q103H");
                if (gotCount[retire.thread] >= expCount[retire.thread]) begin
                    abortRun($sformatf("Thread %0d retired more than expected", retire.thread));
                end
                checkValue($sformatf("T%0d retire %0d rd", retire.thread,
                    gotCount[retire.thread]), xlenT'(expRd[retire.thread][gotCount[retire.thread]]),
                    xlenT'(retire.rd));
                checkValue($sformatf("T%0d retire %0d data", retire.thread,
                    gotCount[retire.thread]), expData[retire.thread][gotCount[retire.thread]],
                    retire.data);
                shadowRegs[retire.thread][retire.rd] = retire.data;
                gotCount[retire.thread]++;
            end
        end else if (retire.valid) begin
            abortRun("Retire valid during reset");
        end
        prevThread = fetchReq.thread;
    end

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////
    initial begin
        int waitCyc;
        rstN       = 1'b0;
        instFetch  = '0;
        lastReq    = '0;
        prevThread = T0;
        cyc        = 0;
        for (int t = 0; t < NUM_THREADS; t++) begin
            expCount[t]    = 0;
            gotCount[t]    = 0;
            firstSeen[t]   = 1'b0;
            expNextPc[t]   = '0;
            jumpPending[t] = 1'b0;
            for (int r = 0; r < REG_COUNT; r++) begin
                shadowRegs[t][r] = '0;
            end
            for (int i = 0; i < MEM_WORDS; i++) begin
                imem[t][i] = ((t * MEM_WORDS + i) << 7) | 32'h0000_000B;  // Unknown opcode
            end
        end
        loadTestdata();

        repeat (3) @(posedge QClk);
        @(negedge QClk);
        rstN <= 1'b1;

        for (int t = 0; t < NUM_THREADS; t++) begin
            waitCyc = 0;
            while (gotCount[t] < expCount[t]) begin
                @(posedge QClk);
                waitCyc++;
                if (waitCyc > TIMEOUT) begin
                    abortRun($sformatf("Thread %0d stalled before all expected retires", t));
                end
            end
        end
        repeat (20) @(posedge QClk);    // Loops must retire nothing more
        $display("Everything OK");
        $finish;
    end

endmodule

// ==== testbench/barrelTestdata.txt ====
# I thread word-index instruction-hex : program words
# E thread rd data-hex : expected retires in thread order
I 0 0 FFB00093
I 0 1 00300113
I 0 2 402081B3
I 0 3 0020A233
I 0 4 0020B2B3
I 0 5 4020D333
I 0 6 0020D3B3
I 0 7 00209433
I 0 8 4010D493
I 0 9 00F0C513
I 0 10 0000006F
E 0 1 FFFFFFFB
E 0 2 00000003
E 0 3 FFFFFFF8
E 0 4 00000001
E 0 5 00000000
E 0 6 FFFFFFFF
E 0 7 1FFFFFFF
E 0 8 FFFFFFD8
E 0 9 FFFFFFFD
E 0 10 FFFFFFF4
I 1 0 01200093
I 1 1 00409113
I 1 2 0020E1B3
I 1 3 0021F233
I 1 4 004182B3
I 1 5 0000006F
E 1 1 00000012
E 1 2 00000120
E 1 3 00000132
E 1 4 00000120
E 1 5 00000252
I 2 0 03500093
I 2 1 00409113
I 2 2 0020E1B3
I 2 3 0021F233
I 2 4 004182B3
I 2 5 0000006F
E 2 1 00000035
E 2 2 00000350
E 2 3 00000375
E 2 4 00000350
E 2 5 000006C5
# Thread 3 not-taken, taken, skipped word per compare type, then jumps
I 3 0 FFF00093
I 3 1 00100113
I 3 2 00208463
I 3 3 00210463
I 3 4 FFF00F93
I 3 5 00211463
I 3 6 00209463
I 3 7 FFF00F93
I 3 8 00114463
I 3 9 0020C463
I 3 10 FFF00F93
I 3 11 0020D463
I 3 12 00115463
I 3 13 FFF00F93
I 3 14 0020E463
I 3 15 00116463
I 3 16 FFF00F93
I 3 17 00117463
I 3 18 0020F463
I 3 19 FFF00F93
I 3 20 123451B7
I 3 21 00001217
I 3 22 008002EF
I 3 23 FFF00F93
I 3 24 00C28367
I 3 25 FFF00F93
I 3 26 0000006F
E 3 1 FFFFFFFF
E 3 2 00000001
E 3 3 12345000
E 3 4 00001354
E 3 5 0000035C
E 3 6 00000364
